//--- hw/pcap_word_pkg.sv
// memory word format and stream widths shared by the capture and replay paths
`default_nettype none

package pcap_word_pkg;

   localparam int DATA_W   = 128;
   localparam int KEEP_W   = 16;
   localparam int USER_W   = 128;
   localparam int CNT_W    = 5;
   localparam int WORD_W   = 144;
   localparam int LAST_BIT = 135;
   localparam int HDR_BIT  = 136;
   localparam int CNT_LSB  = 128;

   // keep is contiguous from byte 0, so the byte count is its population count
   function automatic logic [CNT_W-1:0] keep_to_count(input logic [KEEP_W-1:0] keep);
      logic [CNT_W-1:0] cnt;
      cnt = '0;
      for (int i = 0; i < KEEP_W; i++) begin
         cnt = cnt + CNT_W'(keep[i]);
      end
      return cnt;
   endfunction

   function automatic logic [KEEP_W-1:0] count_to_keep(input logic [CNT_W-1:0] cnt);
      logic [KEEP_W-1:0] keep;
      for (int i = 0; i < KEEP_W; i++) begin
         keep[i] = (i < int'(cnt));
      end
      return keep;
   endfunction

endpackage

`default_nettype wire

//--- hw/pcap_ctrl_pkg.sv
// state encodings of the capture and replay controllers
`default_nettype none

package pcap_ctrl_pkg;

   typedef enum logic [1:0] {
      CAP_IDLE,
      CAP_HEADER,
      CAP_DATA,
      CAP_FLUSH
   } capture_state_e;

   typedef enum logic [1:0] {
      RPL_IDLE,
      RPL_READ,
      RPL_PASS_END
   } replay_state_e;

endpackage

`default_nettype wire

//--- hw/capture_writer.sv
// capture writer that packs the input stream into header and data words and tracks capture status
`default_nettype none

module capture_writer #(
   parameter int ADDR_W = 10
) (
   input  logic                             clk,
   input  logic                             rst_clk,
   input  logic                             s_valid_i,
   input  logic [pcap_word_pkg::DATA_W-1:0] s_data_i,
   input  logic [pcap_word_pkg::KEEP_W-1:0] s_keep_i,
   input  logic [pcap_word_pkg::USER_W-1:0] s_user_i,
   input  logic                             s_last_i,
   input  logic                             capture_done_i,
   input  logic                             replay_busy_i,
   output logic                             s_ready_o,
   output logic                             wr_en_o,
   output logic [ADDR_W-1:0]                wr_addr_o,
   output logic [pcap_word_pkg::WORD_W-1:0] wr_word_o,
   output logic [ADDR_W-1:0]                end_addr_o,
   output logic [31:0]                      pkt_count_o,
   output logic                             capture_busy_o
);
   import pcap_word_pkg::*;
   import pcap_ctrl_pkg::*;

   capture_state_e    state_q;
   capture_state_e    state_d;
   logic [ADDR_W-1:0] addr_q;
   logic [ADDR_W-1:0] addr_d;
   logic              at_last;
   logic              start;

   assign at_last        = (addr_q == {ADDR_W{1'b1}});
   assign start          = s_valid_i && !replay_busy_i;
   assign wr_addr_o      = addr_q;
   assign capture_busy_o = (state_q != CAP_IDLE);

   always_comb begin
      state_d   = state_q;
      addr_d    = addr_q;
      s_ready_o = 1'b0;
      wr_en_o   = 1'b0;
      wr_word_o = '0;
      case (state_q)
         CAP_IDLE: begin
            if (start) begin
               state_d = CAP_HEADER;
               addr_d  = '0;
            end
         end
         CAP_HEADER: begin
            // the source holds the first beat here, so its sideband is still valid
            if (capture_done_i) begin
               state_d = CAP_IDLE;
            end else if (s_valid_i && at_last) begin
               state_d = CAP_FLUSH;
            end else if (s_valid_i) begin
               wr_en_o                = 1'b1;
               wr_word_o[USER_W-1:0]  = s_user_i;
               wr_word_o[HDR_BIT]     = 1'b1;
               addr_d                 = addr_q + 1'b1;
               state_d                = CAP_DATA;
            end
         end
         CAP_DATA: begin
            s_ready_o = s_valid_i;
            if (s_valid_i) begin
               wr_en_o                      = 1'b1;
               wr_word_o[DATA_W-1:0]        = s_data_i;
               wr_word_o[CNT_LSB +: CNT_W]  = keep_to_count(s_keep_i);
               // the word at the last address closes the packet whatever the source says
               wr_word_o[LAST_BIT]          = s_last_i || at_last;
               if (at_last) begin
                  state_d = CAP_FLUSH;
               end else begin
                  addr_d = addr_q + 1'b1;
                  if (s_last_i) begin
                     state_d = CAP_HEADER;
                  end
               end
            end
            if (capture_done_i) begin
               state_d = CAP_IDLE;
            end
         end
         CAP_FLUSH: begin
            s_ready_o = 1'b1;
            if (capture_done_i) begin
               state_d = CAP_IDLE;
            end
         end
         default: begin
            state_d = CAP_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q     <= CAP_IDLE;
         addr_q      <= '0;
         end_addr_o  <= '0;
         pkt_count_o <= '0;
      end else begin
         state_q <= state_d;
         addr_q  <= addr_d;
         if (state_q == CAP_IDLE && start) begin
            end_addr_o  <= '0;
            pkt_count_o <= '0;
         end else if (wr_en_o) begin
            end_addr_o <= wr_addr_o;
            if (wr_word_o[LAST_BIT]) begin
               pkt_count_o <= pkt_count_o + 32'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/capture_buffer.sv
// capture buffer that holds the words in a dual-port memory with a registered read port
`default_nettype none

module capture_buffer #(
   parameter int ADDR_W = 10
) (
   input  logic                             clk,
   input  logic                             rst_clk,
   input  logic                             wr_en_i,
   input  logic [ADDR_W-1:0]                wr_addr_i,
   input  logic [pcap_word_pkg::WORD_W-1:0] wr_word_i,
   input  logic                             rd_en_i,
   input  logic [ADDR_W-1:0]                rd_addr_i,
   output logic [pcap_word_pkg::WORD_W-1:0] rd_word_o,
   output logic                             rd_valid_o
);
   import pcap_word_pkg::*;

   logic [WORD_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_word_i;
      end
      if (rd_en_i) begin
         rd_word_o <= mem[rd_addr_i];
      end
   end

   // the strobe marks the word that was addressed one cycle earlier
   always_ff @(posedge clk) begin
      if (rst_clk) begin
         rd_valid_o <= 1'b0;
      end else begin
         rd_valid_o <= rd_en_i;
      end
   end

endmodule

`default_nettype wire

//--- hw/replay_reader.sv
// replay reader that walks the buffer from address 0 to the end address for a number of passes
`default_nettype none

module replay_reader #(
   parameter int ADDR_W     = 10,
   parameter int FIFO_DEPTH = 4
) (
   input  logic              clk,
   input  logic              rst_clk,
   input  logic              replay_start_i,
   input  logic [15:0]       replay_count_i,
   input  logic [ADDR_W-1:0] end_addr_i,
   input  logic              capture_busy_i,
   input  logic              credit_i,
   output logic              rd_en_o,
   output logic [ADDR_W-1:0] rd_addr_o,
   output logic              replay_busy_o
);
   import pcap_ctrl_pkg::*;

   localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

   replay_state_e     state_q;
   logic [ADDR_W-1:0] addr_q;
   logic [15:0]       count_q;
   logic [15:0]       pass_q;
   // words read but not yet popped by the unpacker, in flight or stored
   logic [CRED_W-1:0] in_flight_q;
   logic              credit_ok;

   assign credit_ok     = (in_flight_q < CRED_W'(FIFO_DEPTH));
   assign rd_en_o       = (state_q == RPL_READ) && credit_ok;
   assign rd_addr_o     = addr_q;
   assign replay_busy_o = (state_q != RPL_IDLE);

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         state_q     <= RPL_IDLE;
         addr_q      <= '0;
         count_q     <= '0;
         pass_q      <= '0;
         in_flight_q <= '0;
      end else begin
         case ({rd_en_o, credit_i})
            2'b10:   in_flight_q <= in_flight_q + 1'b1;
            2'b01:   in_flight_q <= in_flight_q - 1'b1;
            default: in_flight_q <= in_flight_q;
         endcase
         case (state_q)
            RPL_IDLE: begin
               // an end address of 0 means at most a lone header was captured
               if (replay_start_i && !capture_busy_i && end_addr_i != '0) begin
                  count_q <= (replay_count_i == 16'd0) ? 16'd1 : replay_count_i;
                  pass_q  <= '0;
                  addr_q  <= '0;
                  state_q <= RPL_READ;
               end
            end
            RPL_READ: begin
               if (rd_en_o) begin
                  if (addr_q == end_addr_i) begin
                     pass_q  <= pass_q + 16'd1;
                     state_q <= RPL_PASS_END;
                  end else begin
                     addr_q <= addr_q + 1'b1;
                  end
               end
            end
            RPL_PASS_END: begin
               addr_q <= '0;
               // after the final pass, stay busy until every word has left the unpacker
               if (pass_q != count_q) begin
                  state_q <= RPL_READ;
               end else if (in_flight_q == '0) begin
                  state_q <= RPL_IDLE;
               end
            end
            default: begin
               state_q <= RPL_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/replay_unpacker.sv
// replay unpacker that buffers returned words and turns them back into stream beats
`default_nettype none

module replay_unpacker #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                             clk,
   input  logic                             rst_clk,
   input  logic [pcap_word_pkg::WORD_W-1:0] rd_word_i,
   input  logic                             rd_valid_i,
   input  logic                             m_ready_i,
   output logic                             credit_o,
   output logic                             m_valid_o,
   output logic [pcap_word_pkg::DATA_W-1:0] m_data_o,
   output logic [pcap_word_pkg::KEEP_W-1:0] m_keep_o,
   output logic [pcap_word_pkg::USER_W-1:0] m_user_o,
   output logic                             m_last_o
);
   import pcap_word_pkg::*;

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic [WORD_W-1:0] mem [FIFO_DEPTH];
   // pointers carry one extra bit so full and empty can be told apart
   logic [PTR_W:0]    wr_ptr_q;
   logic [PTR_W:0]    rd_ptr_q;
   logic [WORD_W-1:0] head;
   logic [USER_W-1:0] user_q;
   logic              not_empty;
   logic              head_is_hdr;
   logic              pop;

   assign not_empty   = (wr_ptr_q != rd_ptr_q);
   assign head        = mem[rd_ptr_q[PTR_W-1:0]];
   assign head_is_hdr = head[HDR_BIT];

   // a header at the head leaves at once, a data word waits for the sink
   assign pop       = not_empty && (head_is_hdr || m_ready_i);
   assign credit_o  = pop;
   assign m_valid_o = not_empty && !head_is_hdr;
   assign m_data_o  = head[DATA_W-1:0];
   assign m_keep_o  = count_to_keep(head[CNT_LSB +: CNT_W]);
   assign m_user_o  = user_q;
   assign m_last_o  = head[LAST_BIT];

   always_ff @(posedge clk) begin
      if (rd_valid_i) begin
         mem[wr_ptr_q[PTR_W-1:0]] <= rd_word_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_clk) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         user_q   <= '0;
      end else begin
         if (rd_valid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
            // sideband rides on the first beat only
            user_q   <= head_is_hdr ? head[USER_W-1:0] : '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/pcap_replay_top.sv
// packet capture and replay engine built from writer, buffer, reader and unpacker
`default_nettype none

module pcap_replay_top #(
   parameter int ADDR_W     = 10,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                             clk,
   input  logic                             rst_clk,
   input  logic                             s_valid_i,
   input  logic [pcap_word_pkg::DATA_W-1:0] s_data_i,
   input  logic [pcap_word_pkg::KEEP_W-1:0] s_keep_i,
   input  logic [pcap_word_pkg::USER_W-1:0] s_user_i,
   input  logic                             s_last_i,
   output logic                             s_ready_o,
   output logic                             m_valid_o,
   output logic [pcap_word_pkg::DATA_W-1:0] m_data_o,
   output logic [pcap_word_pkg::KEEP_W-1:0] m_keep_o,
   output logic [pcap_word_pkg::USER_W-1:0] m_user_o,
   output logic                             m_last_o,
   input  logic                             m_ready_i,
   input  logic                             capture_done_i,
   input  logic                             replay_start_i,
   input  logic [15:0]                      replay_count_i,
   output logic [31:0]                      pkt_count_o,
   output logic [ADDR_W-1:0]                end_addr_o,
   output logic                             capture_busy_o,
   output logic                             replay_busy_o
);
   import pcap_word_pkg::*;

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [WORD_W-1:0] wr_word;
   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0] rd_word;
   logic              rd_valid;
   logic              credit;

   capture_writer #(
      .ADDR_W(ADDR_W)
   ) u_writer (
      .clk(clk),
      .rst_clk(rst_clk),
      .s_valid_i(s_valid_i),
      .s_data_i(s_data_i),
      .s_keep_i(s_keep_i),
      .s_user_i(s_user_i),
      .s_last_i(s_last_i),
      .capture_done_i(capture_done_i),
      .replay_busy_i(replay_busy_o),
      .s_ready_o(s_ready_o),
      .wr_en_o(wr_en),
      .wr_addr_o(wr_addr),
      .wr_word_o(wr_word),
      .end_addr_o(end_addr_o),
      .pkt_count_o(pkt_count_o),
      .capture_busy_o(capture_busy_o)
   );

   capture_buffer #(
      .ADDR_W(ADDR_W)
   ) u_buffer (
      .clk(clk),
      .rst_clk(rst_clk),
      .wr_en_i(wr_en),
      .wr_addr_i(wr_addr),
      .wr_word_i(wr_word),
      .rd_en_i(rd_en),
      .rd_addr_i(rd_addr),
      .rd_word_o(rd_word),
      .rd_valid_o(rd_valid)
   );

   replay_reader #(
      .ADDR_W(ADDR_W),
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_reader (
      .clk(clk),
      .rst_clk(rst_clk),
      .replay_start_i(replay_start_i),
      .replay_count_i(replay_count_i),
      .end_addr_i(end_addr_o),
      .capture_busy_i(capture_busy_o),
      .credit_i(credit),
      .rd_en_o(rd_en),
      .rd_addr_o(rd_addr),
      .replay_busy_o(replay_busy_o)
   );

   replay_unpacker #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_unpacker (
      .clk(clk),
      .rst_clk(rst_clk),
      .rd_word_i(rd_word),
      .rd_valid_i(rd_valid),
      .m_ready_i(m_ready_i),
      .credit_o(credit),
      .m_valid_o(m_valid_o),
      .m_data_o(m_data_o),
      .m_keep_o(m_keep_o),
      .m_user_o(m_user_o),
      .m_last_o(m_last_o)
   );

endmodule

`default_nettype wire

//--- verif/pcap_replay_sva.sv
// assertions on the stream handshakes and buffer accesses of the capture and replay engine
`default_nettype none

module pcap_replay_sva (
   input logic                             clk,
   input logic                             rst_clk,
   input logic                             s_valid_i,
   input logic                             s_ready_o,
   input logic [pcap_word_pkg::DATA_W-1:0] s_data_i,
   input logic [pcap_word_pkg::KEEP_W-1:0] s_keep_i,
   input logic [pcap_word_pkg::USER_W-1:0] s_user_i,
   input logic                             s_last_i,
   input logic                             m_valid_o,
   input logic                             m_ready_i,
   input logic [pcap_word_pkg::DATA_W-1:0] m_data_o,
   input logic [pcap_word_pkg::KEEP_W-1:0] m_keep_o,
   input logic [pcap_word_pkg::USER_W-1:0] m_user_o,
   input logic                             m_last_o,
   input logic                             wr_en,
   input logic                             rd_en,
   input logic                             capture_busy_o,
   input logic                             replay_busy_o
);
   timeunit 1ns;
   timeprecision 1ps;

   s_beat_held : assert property (@(posedge clk) disable iff (rst_clk)
      s_valid_i && !s_ready_o |=> s_valid_i && $stable({s_data_i, s_keep_i, s_user_i, s_last_i}))
      else $error("capture beat changed while it was stalled");

   m_beat_held : assert property (@(posedge clk) disable iff (rst_clk)
      m_valid_o && !m_ready_i |=> m_valid_o && $stable({m_data_o, m_keep_o, m_user_o, m_last_o}))
      else $error("replay beat changed while it was stalled");

   // the buffer is either being filled or being replayed, never both
   no_read_in_capture : assert property (@(posedge clk) disable iff (rst_clk)
      rd_en |-> !capture_busy_o)
      else $error("buffer read while capture was busy");

   no_write_in_replay : assert property (@(posedge clk) disable iff (rst_clk)
      wr_en |-> !replay_busy_o)
      else $error("buffer write while replay was busy");

   m_idle_after_reset : assert property (@(posedge clk) rst_clk |=> !m_valid_o)
      else $error("replay output valid right after reset");

endmodule

`default_nettype wire

//--- verif/pcap_replay_tb.sv
// testbench of the packet capture and replay engine with directed capture and replay tests
`default_nettype none

module pcap_replay_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import pcap_word_pkg::*;

   localparam int ADDR_W = 6;
   localparam int FIFO_DEPTH = 4;
   localparam int BEAT_W = USER_W + 1 + KEEP_W + DATA_W;
   localparam int LAST_ADDR = 2**ADDR_W - 1;
   localparam int T1_MAX_BEATS = 12;
   localparam int T1_PASSES = 7;
   localparam int T5_PKT_BEATS = 10;
   localparam int T5_PKTS = 7;
   localparam int WATCHDOG_CYCLES =
      (T1_MAX_BEATS * T1_PASSES + 2 * T5_PKT_BEATS * T5_PKTS) * 8 + 1000;

   logic              clk;
   logic              rst_clk;
   logic              s_valid_i;
   logic [DATA_W-1:0] s_data_i;
   logic [KEEP_W-1:0] s_keep_i;
   logic [USER_W-1:0] s_user_i;
   logic              s_last_i;
   logic              s_ready_o;
   logic              m_valid_o;
   logic [DATA_W-1:0] m_data_o;
   logic [KEEP_W-1:0] m_keep_o;
   logic [USER_W-1:0] m_user_o;
   logic              m_last_o;
   logic              m_ready_i;
   logic              capture_done_i;
   logic              replay_start_i;
   logic [15:0]       replay_count_i;
   logic [31:0]       pkt_count_o;
   logic [ADDR_W-1:0] end_addr_o;
   logic              capture_busy_o;
   logic              replay_busy_o;

   logic [31:0]       lfsr_q = 32'hc4a04512;
   // one replay pass as predicted from the word format, with beats packed {user, last, keep, data}
   logic [BEAT_W-1:0] captured_q[$];
   logic [BEAT_W-1:0] got_q[$];
   int                exp_count;
   int                total_beats;

   pcap_replay_top #(
      .ADDR_W(ADDR_W),
      .FIFO_DEPTH(FIFO_DEPTH)
   ) u_dut (
      .clk(clk), .rst_clk(rst_clk),
      .s_valid_i(s_valid_i), .s_data_i(s_data_i), .s_keep_i(s_keep_i),
      .s_user_i(s_user_i), .s_last_i(s_last_i), .s_ready_o(s_ready_o),
      .m_valid_o(m_valid_o), .m_data_o(m_data_o), .m_keep_o(m_keep_o),
      .m_user_o(m_user_o), .m_last_o(m_last_o), .m_ready_i(m_ready_i),
      .capture_done_i(capture_done_i), .replay_start_i(replay_start_i),
      .replay_count_i(replay_count_i), .pkt_count_o(pkt_count_o),
      .end_addr_o(end_addr_o), .capture_busy_o(capture_busy_o),
      .replay_busy_o(replay_busy_o)
   );

   bind pcap_replay_top pcap_replay_sva u_sva (
      .clk(clk), .rst_clk(rst_clk),
      .s_valid_i(s_valid_i), .s_ready_o(s_ready_o), .s_data_i(s_data_i),
      .s_keep_i(s_keep_i), .s_user_i(s_user_i), .s_last_i(s_last_i),
      .m_valid_o(m_valid_o), .m_ready_i(m_ready_i), .m_data_o(m_data_o),
      .m_keep_o(m_keep_o), .m_user_o(m_user_o), .m_last_o(m_last_o),
      .wr_en(wr_en), .rd_en(rd_en),
      .capture_busy_o(capture_busy_o), .replay_busy_o(replay_busy_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(negedge clk) begin
      if (!rst_clk && m_valid_o && m_ready_i) begin
         got_q.push_back({m_user_o, m_last_o, m_keep_o, m_data_o});
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired before the tests finished");
      $display("Done: errors found");
      $fatal(1);
   end

   function automatic logic [127:0] take_bits(input int n);
      logic [127:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
         bits[i] = lfsr_q[0];
      end
      return bits;
   endfunction

   task automatic report_mismatch(input string name, input logic [BEAT_W-1:0] exp,
                                  input logic [BEAT_W-1:0] act);
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1);
   endtask

   // called just after a rising edge and returns at the edge where the beat transferred
   task automatic send_beat(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                            input logic [USER_W-1:0] user, input logic last, output int waited);
      s_valid_i <= 1'b1;
      s_data_i  <= data;
      s_keep_i  <= keep;
      s_user_i  <= user;
      s_last_i  <= last;
      waited = 0;
      @(negedge clk);
      while (!s_ready_o) begin
         waited++;
         @(negedge clk);
      end
      @(posedge clk);
   endtask

   // a fixed_len of 0 picks 1 to 4 beats per packet
   task automatic capture_packets(input string name, input int num_pkts, input int fixed_len);
      int                addr;
      int                len;
      int                waited;
      int                dropped;
      bit                cut;
      logic [USER_W-1:0] user;
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
      logic              last;
      addr = 0;
      dropped = 0;
      cut = 1'b0;
      exp_count = 0;
      total_beats = 0;
      captured_q.delete();
      @(posedge clk);
      for (int p = 0; p < num_pkts; p++) begin
         len = (fixed_len == 0) ? 1 + int'(take_bits(2)) : fixed_len;
         user = take_bits(USER_W);
         if (!cut && addr == LAST_ADDR) begin
            cut = 1'b1;
         end else if (!cut) begin
            addr++;
         end
         for (int b = 0; b < len; b++) begin
            keep = 16'hffff >> (16 - (1 + int'(take_bits(4))));
            data = take_bits(DATA_W);
            for (int k = 0; k < KEEP_W; k++) begin
               if (!keep[k]) begin
                  data[k*8 +: 8] = 8'h00;
               end
            end
            last = (b == len - 1);
            total_beats++;
            if (cut) begin
               dropped++;
            end else begin
               captured_q.push_back({(b == 0) ? user : {USER_W{1'b0}},
                                     last || addr == LAST_ADDR, keep, data});
               if (last || addr == LAST_ADDR) begin
                  exp_count++;
               end
               if (addr == LAST_ADDR) begin
                  cut = 1'b1;
               end else begin
                  addr++;
               end
            end
            send_beat(data, keep, user, last, waited);
            if (dropped > 1) begin
               assert (waited == 0)
                  else fail_run({name, ": a beat after the cut was not accepted at once"});
            end
         end
      end
      s_valid_i <= 1'b0;
      s_last_i  <= 1'b0;
      capture_done_i <= 1'b1;
      @(posedge clk);
      capture_done_i <= 1'b0;
      @(posedge clk);
      @(negedge clk);
      assert (!capture_busy_o) else fail_run({name, ": capture stayed busy after done"});
   endtask

   task automatic run_replay(input string name, input logic [15:0] count, input int passes,
                             input bit random_ready);
      int                n;
      logic [127:0]      r;
      logic [BEAT_W-1:0] exp;
      n = captured_q.size();
      got_q.delete();
      @(posedge clk);
      replay_count_i <= count;
      replay_start_i <= 1'b1;
      @(posedge clk);
      replay_start_i <= 1'b0;
      @(negedge clk);
      assert (replay_busy_o) else fail_run({name, ": replay did not start"});
      do begin
         @(posedge clk);
         r = take_bits(1);
         m_ready_i <= random_ready ? r[0] : 1'b1;
         @(negedge clk);
      end while (replay_busy_o);
      @(posedge clk);
      m_ready_i <= 1'b1;
      assert (got_q.size() == passes * n)
         else report_mismatch({name, " beat count"}, BEAT_W'(passes * n), BEAT_W'(got_q.size()));
      for (int i = 0; i < got_q.size(); i++) begin
         exp = captured_q[i % n];
         assert (got_q[i] == exp) else report_mismatch(name, exp, got_q[i]);
      end
   endtask

   initial begin
      rst_clk = 1'b1;
      s_valid_i = 1'b0;
      s_data_i = '0;
      s_keep_i = '0;
      s_user_i = '0;
      s_last_i = 1'b0;
      m_ready_i = 1'b1;
      capture_done_i = 1'b0;
      replay_start_i = 1'b0;
      replay_count_i = '0;
      repeat (4) @(posedge clk);
      rst_clk <= 1'b0;
      repeat (2) @(posedge clk);

      capture_packets("test1", 3, 0);
      assert (pkt_count_o == 32'd3)
         else report_mismatch("test2 packet count", BEAT_W'(3), BEAT_W'(pkt_count_o));
      assert (int'(end_addr_o) == 3 + total_beats - 1)
         else report_mismatch("test2 end address", BEAT_W'(3 + total_beats - 1),
                              BEAT_W'(end_addr_o));
      run_replay("test1", 16'd1, 1, 1'b0);
      run_replay("test3 count 3", 16'd3, 3, 1'b0);
      run_replay("test3 count 0", 16'd0, 1, 1'b0);
      run_replay("test4", 16'd1, 1, 1'b1);

      capture_packets("test5", T5_PKTS, T5_PKT_BEATS);
      assert (pkt_count_o == 32'(exp_count))
         else report_mismatch("test5 packet count", BEAT_W'(exp_count), BEAT_W'(pkt_count_o));
      assert (int'(end_addr_o) == LAST_ADDR)
         else report_mismatch("test5 end address", BEAT_W'(LAST_ADDR), BEAT_W'(end_addr_o));
      run_replay("test5", 16'd1, 1, 1'b0);

      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- pcap_replay_top.f
hw/pcap_word_pkg.sv
hw/pcap_ctrl_pkg.sv
hw/capture_writer.sv
hw/capture_buffer.sv
hw/replay_reader.sv
hw/replay_unpacker.sv
hw/pcap_replay_top.sv
verif/pcap_replay_sva.sv
verif/pcap_replay_tb.sv

//--- Bender.yml
package:
  name: pcap_replay

sources:
  - hw/pcap_word_pkg.sv
  - hw/pcap_ctrl_pkg.sv
  - hw/capture_writer.sv
  - hw/capture_buffer.sv
  - hw/replay_reader.sv
  - hw/replay_unpacker.sv
  - hw/pcap_replay_top.sv
  - target: test
    files:
      - verif/pcap_replay_sva.sv
      - verif/pcap_replay_tb.sv
